//--- trs_video_consts.svh
`ifndef TRS_VIDEO_CONSTS_SVH
`define TRS_VIDEO_CONSTS_SVH

// horizontal raster, counted in 8-pixel cells
`define TRS_CELL_PIX       8
`define TRS_H_CELLS        100   // 800 clocks per line
`define TRS_H_ACT_CELLS    80
`define TRS_HS_ON_CELL     82
`define TRS_HS_OFF_CELL    94
`define TRS_HS_PIX         2     // pixel slot of both sync edges

// vertical raster per mode, rows of character lines
`define TRS_ROWS_80        24
`define TRS_LINES_80       20
`define TRS_LAST_ROW_80    26
`define TRS_LAST_LINE_80   4
`define TRS_ROWS_64        20
`define TRS_LINES_64       24
`define TRS_LAST_ROW_64    21
`define TRS_LAST_LINE_64   20
`define TRS_VS_ON_LINE     9
`define TRS_VS_OFF_LINE    11

`define TRS_TEXT_X_OFS     8     // 64x16 centring, cells
`define TRS_TEXT_Y_OFS     2     // rows

`define TRS_DISP_DEPTH     2048
`define TRS_GLYPH_DEPTH    4096
`define TRS_ADDR_DISP      16'h0000
`define TRS_ADDR_GLYPH     16'h4000
`define TRS_ADDR_CTRL      16'h8000
`define TRS_CTRL_RESET     3'b000

`endif

//--- trs_video_pkg.sv
package trs_video_pkg;

   typedef logic [7:0]  code_t;
   typedef logic [10:0] disp_addr_t;
   typedef logic [11:0] glyph_addr_t;   // {mapped code, glyph row}
   typedef logic [6:0]  cell_x_t;
   typedef logic [2:0]  cell_pix_t;
   typedef logic [4:0]  row_t;
   typedef logic [4:0]  line_t;
   typedef logic [15:0] axil_addr_t;
   typedef logic [31:0] axil_data_t;

   // master side of the AXI4-Lite link
   typedef struct packed {
      axil_addr_t aw_addr;
      logic       aw_valid;
      axil_data_t w_data;
      logic [3:0] w_strb;
      logic       w_valid;
      logic       b_ready;
      axil_addr_t ar_addr;
      logic       ar_valid;
      logic       r_ready;
   } axil_req_t;

   // slave side
   typedef struct packed {
      logic       aw_ready;
      logic       w_ready;
      logic       b_valid;
      logic [1:0] b_resp;
      logic       ar_ready;
      logic       r_valid;
      axil_data_t r_data;
      logic [1:0] r_resp;
   } axil_rsp_t;

   // bit 2 mode, bit 1 inverse, bit 0 alternate set
   typedef struct packed {
      logic mode_80x24;
      logic inv_video;
      logic alt_set;
   } video_ctrl_t;

   typedef struct packed {
      cell_x_t   cell_x;
      cell_pix_t pix;
      row_t      row;
      line_t     line;
      logic      in_active;    // inside 640x480
      logic      in_text;      // inside text window of latched mode
      logic      mode_80x24;   // latched at frame wrap
   } beam_t;

   typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
   typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA, RD_RESP} rd_state_t;

endpackage

//--- video_ram.sv
`timescale 1ns/1ps
`include "trs_video_consts.svh"

module video_ram import trs_video_pkg::*;
#(
   parameter int DEPTH = `TRS_DISP_DEPTH,
   localparam int AW = $clog2(DEPTH)
)
(
   input  logic          vga_clk,
   input  logic          a_en,
   input  logic          a_we,
   input  logic [AW-1:0] a_addr,
   input  code_t         a_wdata,
   output code_t         a_rdata,
   input  logic          b_en,
   input  logic [AW-1:0] b_addr,
   output code_t         b_rdata
);

   code_t mem [DEPTH];

   // host port, read returns the old byte on a write
   always_ff @(posedge vga_clk)
   begin
      if (a_en)
      begin
         if (a_we)
            mem[a_addr] <= a_wdata;
         a_rdata <= mem[a_addr];
      end
   end

   // video port, output holds between reads
   always_ff @(posedge vga_clk)
   begin
      if (b_en)
         b_rdata <= mem[b_addr];
   end

endmodule

//--- host_bus_port.sv
`timescale 1ns/1ps
`include "trs_video_consts.svh"

module host_bus_port import trs_video_pkg::*;
(
   input  logic        vga_clk,
   input  logic        arst_n,
   input  axil_req_t   axil_req,
   output axil_rsp_t   axil_rsp,
   output video_ctrl_t video_ctrl,
   output logic        disp_a_en,
   output logic        disp_a_we,
   output logic        glyph_a_en,
   output logic        glyph_a_we,
   output glyph_addr_t host_a_addr,
   output code_t       host_a_wdata,
   input  code_t       disp_a_rdata,
   input  code_t       glyph_a_rdata
);

   localparam logic [1:0] RGN_NONE  = 2'd0;
   localparam logic [1:0] RGN_DISP  = 2'd1;
   localparam logic [1:0] RGN_GLYPH = 2'd2;
   localparam logic [1:0] RGN_CTRL  = 2'd3;
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // byte address to target region, low two bits ignored
   function automatic logic [1:0] region(axil_addr_t a);
      logic [1:0] r;
      r = RGN_NONE;
      if (a >= `TRS_ADDR_DISP && a < `TRS_ADDR_DISP + 4 * `TRS_DISP_DEPTH)
         r = RGN_DISP;
      else if (a >= `TRS_ADDR_GLYPH && a < `TRS_ADDR_GLYPH + 4 * `TRS_GLYPH_DEPTH)
         r = RGN_GLYPH;
      else if ({a[15:2], 2'b00} == `TRS_ADDR_CTRL)
         r = RGN_CTRL;
      return r;
   endfunction

   wr_state_t   wr_state;
   rd_state_t   rd_state;
   logic        wr_go;       // aw+w handshake this cycle
   logic        rd_issue;    // read owns port A this cycle
   logic        wr_byte;
   logic [1:0]  wr_rgn;
   logic [1:0]  rd_rgn;
   axil_addr_t  rd_addr;
   axil_data_t  r_data;
   logic [1:0]  r_resp;
   logic [1:0]  b_resp;
   video_ctrl_t ctrl_q;

   assign wr_rgn   = region(axil_req.aw_addr);
   assign rd_rgn   = region(rd_addr);
   assign wr_go    = axil_req.aw_valid && axil_req.w_valid && (wr_state == WR_IDLE);
   assign rd_issue = (rd_state == RD_ADDR) && !wr_go;   // write wins port A
   assign wr_byte  = wr_go && axil_req.w_strb[0];

   // port A, write has priority over the pending read
   assign host_a_addr  = wr_go ? axil_req.aw_addr[13:2] : rd_addr[13:2];
   assign host_a_wdata = axil_req.w_data[7:0];
   assign disp_a_en    = (wr_go && wr_rgn == RGN_DISP) || (rd_issue && rd_rgn == RGN_DISP);
   assign glyph_a_en   = (wr_go && wr_rgn == RGN_GLYPH) || (rd_issue && rd_rgn == RGN_GLYPH);
   assign disp_a_we    = wr_byte && wr_rgn == RGN_DISP;
   assign glyph_a_we   = wr_byte && wr_rgn == RGN_GLYPH;
   assign video_ctrl   = ctrl_q;

   always_ff @(posedge vga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_state <= WR_IDLE;
         rd_state <= RD_IDLE;
         ctrl_q   <= `TRS_CTRL_RESET;
      end
      else
      begin
         case (wr_state)
            WR_IDLE: if (wr_go) wr_state <= WR_RESP;
            WR_RESP: if (axil_req.b_ready) wr_state <= WR_IDLE;
         endcase
         if (wr_byte && wr_rgn == RGN_CTRL)
            ctrl_q <= video_ctrl_t'(axil_req.w_data[2:0]);
         case (rd_state)
            RD_IDLE: if (axil_req.ar_valid) rd_state <= RD_ADDR;
            RD_ADDR: if (!wr_go) rd_state <= RD_DATA;   // one cycle stall on collision
            RD_DATA: rd_state <= RD_RESP;
            RD_RESP: if (axil_req.r_ready) rd_state <= RD_IDLE;
         endcase
      end
   end

   // response payload
   always_ff @(posedge vga_clk)
   begin
      if (wr_go)
         b_resp <= (wr_rgn == RGN_NONE) ? RESP_SLVERR : RESP_OKAY;
      if (rd_state == RD_IDLE && axil_req.ar_valid)
         rd_addr <= axil_req.ar_addr;
      if (rd_state == RD_DATA)
      begin
         r_resp <= RESP_OKAY;
         case (rd_rgn)
            RGN_DISP:  r_data <= {24'd0, disp_a_rdata};
            RGN_GLYPH: r_data <= {24'd0, glyph_a_rdata};
            RGN_CTRL:  r_data <= {29'd0, ctrl_q};
            default:
            begin
               r_data <= '0;
               r_resp <= RESP_SLVERR;
            end
         endcase
      end
   end

   always_comb
   begin
      axil_rsp.aw_ready = wr_go;
      axil_rsp.w_ready  = wr_go;
      axil_rsp.b_valid  = (wr_state == WR_RESP);
      axil_rsp.b_resp   = b_resp;
      axil_rsp.ar_ready = (rd_state == RD_IDLE);
      axil_rsp.r_valid  = (rd_state == RD_RESP);
      axil_rsp.r_data   = r_data;
      axil_rsp.r_resp   = r_resp;
   end

   // responses stay up until the master takes them
   a_b_hold: assert property (@(posedge vga_clk) disable iff (!arst_n)
      axil_rsp.b_valid && !axil_req.b_ready |=> axil_rsp.b_valid);
   a_r_hold: assert property (@(posedge vga_clk) disable iff (!arst_n)
      axil_rsp.r_valid && !axil_req.r_ready |=> axil_rsp.r_valid && $stable(axil_rsp.r_data));

endmodule

//--- raster_timing.sv
`timescale 1ns/1ps
`include "trs_video_consts.svh"

module raster_timing import trs_video_pkg::*;
(
   input  logic        vga_clk,
   input  logic        arst_n,
   input  video_ctrl_t video_ctrl,
   output beam_t       beam,
   output logic        h_sync,
   output logic        v_sync,
   output logic        is_80col
);

   cell_pix_t pix;
   cell_x_t   cell_x;
   row_t      row;
   line_t     line;
   logic      mode_80;      // latched mode
   row_t      rows_act;     // also the v_sync row
   row_t      last_row;
   line_t     last_line;    // frame ends here
   line_t     row_wrap;     // last line of a row
   cell_x_t   col_ofs;
   row_t      row_ofs;
   logic      cell_end;
   logic      line_end;
   logic      in_active;
   logic      in_text;

   assign rows_act  = mode_80 ? row_t'(`TRS_ROWS_80) : row_t'(`TRS_ROWS_64);
   assign last_row  = mode_80 ? row_t'(`TRS_LAST_ROW_80) : row_t'(`TRS_LAST_ROW_64);
   assign last_line = mode_80 ? line_t'(`TRS_LAST_LINE_80) : line_t'(`TRS_LAST_LINE_64);
   assign row_wrap  = mode_80 ? line_t'(`TRS_LINES_80 - 1) : line_t'(`TRS_LINES_64 - 1);
   assign cell_end  = (pix == cell_pix_t'(`TRS_CELL_PIX - 1));
   assign line_end  = cell_end && (cell_x == cell_x_t'(`TRS_H_CELLS - 1));

   // text window, offsets wrap high so one compare each
   assign col_ofs   = cell_x - cell_x_t'(`TRS_TEXT_X_OFS);
   assign row_ofs   = row - row_t'(`TRS_TEXT_Y_OFS);
   assign in_active = (cell_x < `TRS_H_ACT_CELLS) && (row < rows_act);
   assign in_text   = mode_80 ? in_active :
                      (col_ofs < `TRS_H_ACT_CELLS - 2 * `TRS_TEXT_X_OFS) &&
                      (row_ofs < `TRS_ROWS_64 - 2 * `TRS_TEXT_Y_OFS);

   always_ff @(posedge vga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         pix     <= '0;
         cell_x  <= '0;
         line    <= '0;
         row     <= '0;
         mode_80 <= 1'b0;   // 64x16 out of reset
      end
      else
      begin
         pix <= pix + 1'b1;   // wraps at 8
         if (cell_end)
            cell_x <= line_end ? '0 : cell_x + 1'b1;
         if (line_end)
         begin
            if (row == last_row && line == last_line)
            begin
               row     <= '0;
               line    <= '0;
               mode_80 <= video_ctrl.mode_80x24;   // mode only changes here
            end
            else if (line == row_wrap)
            begin
               line <= '0;
               row  <= row + 1'b1;
            end
            else
               line <= line + 1'b1;
         end
      end
   end

   // beam and syncs share one register stage
   always_ff @(posedge vga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         beam   <= '0;
         h_sync <= 1'b0;
         v_sync <= 1'b0;
      end
      else
      begin
         beam <= '{cell_x: cell_x, pix: pix, row: row, line: line,
                   in_active: in_active, in_text: in_text, mode_80x24: mode_80};
         if (cell_x == `TRS_HS_ON_CELL && pix == `TRS_HS_PIX)
            h_sync <= 1'b1;
         else if (cell_x == `TRS_HS_OFF_CELL && pix == `TRS_HS_PIX)
            h_sync <= 1'b0;
         if (row == rows_act && line == `TRS_VS_ON_LINE)
            v_sync <= 1'b1;   // 2 lines in first blank row
         else if (row == rows_act && line == `TRS_VS_OFF_LINE)
            v_sync <= 1'b0;
      end
   end

   assign is_80col = mode_80;

   a_hs_blank: assert property (@(posedge vga_clk) disable iff (!arst_n)
      h_sync |-> !beam.in_active);

endmodule

//--- glyph_shifter.sv
`timescale 1ns/1ps
`include "trs_video_consts.svh"

module glyph_shifter import trs_video_pkg::*;
(
   input  logic        vga_clk,
   input  logic        arst_n,
   input  beam_t       beam,
   input  video_ctrl_t video_ctrl,
   output logic        disp_b_en,
   output disp_addr_t  disp_b_addr,
   input  code_t       disp_b_rdata,
   output logic        glyph_b_en,
   output glyph_addr_t glyph_b_addr,
   input  code_t       glyph_b_rdata,
   output logic        pixel_data,
   output logic        pixel_de
);

   logic [3:0] glyph_row;   // each glyph row drawn on two lines
   cell_x_t    col_ofs;
   row_t       row_ofs;
   code_t      mapped;
   code_t      code_q;      // raw code of the cell being fetched
   code_t      blk_byte;
   code_t      load_byte;
   logic       is_block;
   logic [7:0] shift_q;
   logic [4:0] de_dly;      // matches the five clock fetch latency

   assign glyph_row = beam.line[4:1];
   assign col_ofs   = beam.cell_x - cell_x_t'(`TRS_TEXT_X_OFS);
   assign row_ofs   = beam.row - row_t'(`TRS_TEXT_Y_OFS);

   // pix 0, display RAM read
   assign disp_b_en   = beam.in_text && beam.pix == 3'd0;
   assign disp_b_addr = beam.mode_80x24 ?
                        disp_addr_t'({beam.row, 6'b0}) + disp_addr_t'({beam.row, 4'b0}) +
                        disp_addr_t'(beam.cell_x) :          // 80*row + col
                        disp_addr_t'({row_ofs[3:0], col_ofs[5:0]});

   // pix 2, code valid and character generator read
   assign mapped = {disp_b_rdata[7] & ~video_ctrl.inv_video,
                    disp_b_rdata[6] & ~(disp_b_rdata[7] & video_ctrl.alt_set),
                    disp_b_rdata[5:0]};
   assign glyph_b_en   = beam.in_text && beam.pix == 3'd2;
   assign glyph_b_addr = {mapped, glyph_row};

   always_ff @(posedge vga_clk)
   begin
      if (glyph_b_en)
         code_q <= disp_b_rdata;
   end

   // 10xxxxxx without inverse is a 2x3 block graphic
   assign is_block = (code_q[7:6] == 2'b10) && !video_ctrl.inv_video;

   always_comb
   begin
      case (glyph_row[3:2])   // pair of blocks per third of the cell
         2'd0:    blk_byte = {{4{code_q[0]}}, {4{code_q[1]}}};
         2'd1:    blk_byte = {{4{code_q[2]}}, {4{code_q[3]}}};
         2'd2:    blk_byte = {{4{code_q[4]}}, {4{code_q[5]}}};
         default: blk_byte = 8'h00;
      endcase
      if (!beam.in_text)
         load_byte = 8'h00;   // border and blanking
      else if (is_block)
         load_byte = blk_byte;
      else
         load_byte = glyph_b_rdata ^ {8{code_q[7] & video_ctrl.inv_video}};
   end

   // pix 4 load, msb out first from pix 5
   always_ff @(posedge vga_clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         shift_q <= '0;
         de_dly  <= '0;
      end
      else
      begin
         de_dly <= {de_dly[3:0], beam.in_active};
         if (beam.pix == 3'd4)
            shift_q <= load_byte;
         else
            shift_q <= {shift_q[6:0], 1'b0};
      end
   end

   assign pixel_data = shift_q[7];
   assign pixel_de   = de_dly[4];

endmodule

//--- trs_video_top.sv
`timescale 1ns/1ps
`include "trs_video_consts.svh"

module trs_video_top import trs_video_pkg::*;
(
   input  logic      vga_clk,
   input  logic      arst_n,
   input  axil_req_t axil_req,
   output axil_rsp_t axil_rsp,
   output logic      pixel_data,
   output logic      pixel_de,
   output logic      h_sync,
   output logic      v_sync,
   output logic      is_80col
);

   video_ctrl_t video_ctrl;
   beam_t       beam;
   glyph_addr_t host_a_addr;    // shared port A index, disp uses low 11 bits
   code_t       host_a_wdata;
   code_t       disp_a_rdata;
   code_t       glyph_a_rdata;
   logic        disp_a_en;
   logic        disp_a_we;
   logic        glyph_a_en;
   logic        glyph_a_we;
   logic        disp_b_en;
   disp_addr_t  disp_b_addr;
   code_t       disp_b_rdata;
   logic        glyph_b_en;
   glyph_addr_t glyph_b_addr;
   code_t       glyph_b_rdata;

   host_bus_port i_host_bus_port (
      .vga_clk       (vga_clk),
      .arst_n        (arst_n),
      .axil_req      (axil_req),
      .axil_rsp      (axil_rsp),
      .video_ctrl    (video_ctrl),
      .disp_a_en     (disp_a_en),
      .disp_a_we     (disp_a_we),
      .glyph_a_en    (glyph_a_en),
      .glyph_a_we    (glyph_a_we),
      .host_a_addr   (host_a_addr),
      .host_a_wdata  (host_a_wdata),
      .disp_a_rdata  (disp_a_rdata),
      .glyph_a_rdata (glyph_a_rdata)
   );

   // display RAM, 2k codes
   video_ram #(.DEPTH(`TRS_DISP_DEPTH)) i_disp_ram (
      .vga_clk (vga_clk),
      .a_en    (disp_a_en),
      .a_we    (disp_a_we),
      .a_addr  (host_a_addr[10:0]),
      .a_wdata (host_a_wdata),
      .a_rdata (disp_a_rdata),
      .b_en    (disp_b_en),
      .b_addr  (disp_b_addr),
      .b_rdata (disp_b_rdata)
   );

   // character generator, 256 codes x 16 rows
   video_ram #(.DEPTH(`TRS_GLYPH_DEPTH)) i_glyph_ram (
      .vga_clk (vga_clk),
      .a_en    (glyph_a_en),
      .a_we    (glyph_a_we),
      .a_addr  (host_a_addr),
      .a_wdata (host_a_wdata),
      .a_rdata (glyph_a_rdata),
      .b_en    (glyph_b_en),
      .b_addr  (glyph_b_addr),
      .b_rdata (glyph_b_rdata)
   );

   raster_timing i_raster_timing (
      .vga_clk    (vga_clk),
      .arst_n     (arst_n),
      .video_ctrl (video_ctrl),
      .beam       (beam),
      .h_sync     (h_sync),
      .v_sync     (v_sync),
      .is_80col   (is_80col)
   );

   glyph_shifter i_glyph_shifter (
      .vga_clk       (vga_clk),
      .arst_n        (arst_n),
      .beam          (beam),
      .video_ctrl    (video_ctrl),
      .disp_b_en     (disp_b_en),
      .disp_b_addr   (disp_b_addr),
      .disp_b_rdata  (disp_b_rdata),
      .glyph_b_en    (glyph_b_en),
      .glyph_b_addr  (glyph_b_addr),
      .glyph_b_rdata (glyph_b_rdata),
      .pixel_data    (pixel_data),
      .pixel_de      (pixel_de)
   );

endmodule

//--- tb_trs_video.sv
`timescale 1ns/1ps
`include "trs_video_consts.svh"

module tb_trs_video import trs_video_pkg::*; ();

   localparam int CLK_NS = 4;
   localparam int ACT_PIX = `TRS_H_ACT_CELLS * `TRS_CELL_PIX;    // 640
   localparam int ACT_LINES = `TRS_ROWS_80 * `TRS_LINES_80;      // 480
   localparam longint LINE_NS = `TRS_H_CELLS * `TRS_CELL_PIX * CLK_NS;
   localparam longint FRAME_NS = (`TRS_LAST_ROW_80 * `TRS_LINES_80 + `TRS_LAST_LINE_80 + 1)
                                 * LINE_NS;
   localparam int HS_LIMIT = 64;   // clocks allowed for one AXI handshake

   typedef struct packed {
      logic [7:0]  kind;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
   } test_op_t;

   logic      vga_clk;
   logic      arst_n;
   axil_req_t axil_req;
   axil_rsp_t axil_rsp;
   logic      pixel_data;
   logic      pixel_de;
   logic      h_sync;
   logic      v_sync;
   logic      is_80col;

   test_op_t          ops[$];
   logic [ACT_PIX-1:0] frame_lines [ACT_LINES];   // last captured frame
   longint            cycle = 0;
   longint            watchdog_ns = 0;
   int                errors = 0;
   int                checks = 0;
   int                tests_failed = 0;

   trs_video_top i_trs_video_top (
      .vga_clk    (vga_clk),
      .arst_n     (arst_n),
      .axil_req   (axil_req),
      .axil_rsp   (axil_rsp),
      .pixel_data (pixel_data),
      .pixel_de   (pixel_de),
      .h_sync     (h_sync),
      .v_sync     (v_sync),
      .is_80col   (is_80col)
   );

   initial
   begin
      vga_clk = 1'b0;
      forever #(CLK_NS / 2) vga_clk = ~vga_clk;
   end

   always @(posedge vga_clk)
      cycle <= cycle + 1;   // time base for sync widths

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         $display("FAIL %s expected %0h got %0h", name, expected, actual);
         errors++;
      end
   endtask

   function automatic logic rsp_flag(input int sel);
      case (sel)
         0:       return axil_rsp.aw_ready;
         1:       return axil_rsp.b_valid;
         2:       return axil_rsp.ar_ready;
         default: return axil_rsp.r_valid;
      endcase
   endfunction

   // samples on falling edges and returns at the one that sees the flag
   task automatic wait_rsp(input int sel, input string what);
      int n;
      n = 0;
      @(negedge vga_clk);
      while (!rsp_flag(sel) && n < HS_LIMIT)
      begin
         @(negedge vga_clk);
         n++;
      end
      if (!rsp_flag(sel))
      begin
         $display("%s did not arrive within %0d clocks", what, HS_LIMIT);
         errors++;
      end
   endtask

   task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                             output logic [1:0] resp);
      int stall;
      stall = $urandom % 4;   // b_ready back-pressure
      @(posedge vga_clk);
      axil_req.aw_addr  <= addr;
      axil_req.aw_valid <= 1'b1;
      axil_req.w_data   <= data;
      axil_req.w_strb   <= 4'hf;
      axil_req.w_valid  <= 1'b1;
      wait_rsp(0, "aw_ready");
      check_value("w_ready", 1, {31'd0, axil_rsp.w_ready});   // taken with aw
      @(posedge vga_clk);   // accepted on this edge
      axil_req.aw_valid <= 1'b0;
      axil_req.w_valid  <= 1'b0;
      wait_rsp(1, "b_valid");
      resp = axil_rsp.b_resp;
      repeat (stall) @(posedge vga_clk);
      @(posedge vga_clk);
      axil_req.b_ready <= 1'b1;
      @(posedge vga_clk);
      axil_req.b_ready <= 1'b0;
   endtask

   task automatic axil_read(input axil_addr_t addr, output axil_data_t data,
                            output logic [1:0] resp);
      int stall;
      stall = $urandom % 4;   // r_ready back-pressure
      @(posedge vga_clk);
      axil_req.ar_addr  <= addr;
      axil_req.ar_valid <= 1'b1;
      wait_rsp(2, "ar_ready");
      @(posedge vga_clk);
      axil_req.ar_valid <= 1'b0;
      wait_rsp(3, "r_valid");
      data = axil_rsp.r_data;
      resp = axil_rsp.r_resp;
      repeat (stall) @(posedge vga_clk);
      @(posedge vga_clk);
      axil_req.r_ready <= 1'b1;
      @(posedge vga_clk);
      axil_req.r_ready <= 1'b0;
   endtask

   function automatic logic sync_level(input int sel);
      return (sel == 0) ? h_sync : v_sync;
   endfunction

   // rise to fall to rise measured in clocks
   task automatic measure_pulse(input int sel, output longint width, output longint period);
      longint t_rise;
      @(negedge vga_clk);
      while (sync_level(sel))
         @(negedge vga_clk);
      while (!sync_level(sel))
         @(negedge vga_clk);
      t_rise = cycle;
      while (sync_level(sel))
         @(negedge vga_clk);
      width = cycle - t_rise;
      while (!sync_level(sel))
         @(negedge vga_clk);
      period = cycle - t_rise;
   endtask

   task automatic check_sync(input test_op_t op);
      longint wid;
      longint per;
      measure_pulse(0, wid, per);
      check_value("h_sync period", op.a, 32'(per));
      check_value("h_sync width", op.b, 32'(wid));
      measure_pulse(1, wid, per);
      check_value("v_sync width", op.c, 32'(wid));
      check_value("v_sync period", op.d, 32'(per));
   endtask

   // waits for the v_sync fall and grabs every pixel_de line of the next frame
   task automatic capture_frame(input logic exp_80);
      int x;
      @(negedge vga_clk);
      while (!v_sync)
         @(negedge vga_clk);
      while (v_sync)
         @(negedge vga_clk);
      for (int l = 0; l < ACT_LINES; l++)
      begin
         while (!pixel_de)
            @(negedge vga_clk);
         if (l == 0)
            check_value("is_80col", {31'd0, exp_80}, {31'd0, is_80col});   // mode now latched
         x = 0;
         while (pixel_de)
         begin
            if (x < ACT_PIX)
               frame_lines[l][x] = pixel_data;
            x++;
            @(negedge vga_clk);
         end
         check_value("pixel_de run length", ACT_PIX, x);
      end
   endtask

   task automatic load_tests();
      int          fd;
      int          n;
      int          frame_ops;
      string       op;
      logic [7:0]  kind;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
      logic [1023:0] rest;
      frame_ops = 0;
      fd = $fopen("tb_testdata.txt", "r");
      if (fd == 0)
      begin
         $display("could not open tb_testdata.txt");
         errors++;
         n = 0;
      end
      else
         n = $fscanf(fd, "%s", op);
      while (n == 1)
      begin
         kind = op.getc(0);
         {a, b, c, d} = '0;
         if (kind == "#")
            void'($fgets(rest, fd));   // column notes
         else
         begin
            case (kind)
               "W", "R": n = $fscanf(fd, "%h %h %h", a, b, c);
               "F":      n = $fscanf(fd, "%d", a);
               "P":      n = $fscanf(fd, "%d %d %d", a, b, c);
               "S":      n = $fscanf(fd, "%d %d %d %d", a, b, c, d);
               default:  n = 0;
            endcase
            if (n < 1)
            begin
               $display("unreadable operation %s in tb_testdata.txt", op);
               errors++;
            end
            else
               ops.push_back('{kind: kind, a: a, b: b, c: c, d: d});
            if (kind == "F" || kind == "S")
               frame_ops++;
         end
         n = $fscanf(fd, "%s", op);
      end
      if (fd != 0)
         $fclose(fd);
      watchdog_ns = frame_ops * 2 * FRAME_NS + FRAME_NS + ops.size() * 2000;
   endtask

   initial
   begin
      wait (watchdog_ns > 0);
      #(watchdog_ns);
      $display("watchdog expired after %0d ns, the run is stuck", watchdog_ns);
      $display("SOME TESTS FAILED");
      $finish;
   end

   initial
   begin
      axil_data_t  rdata;
      logic [1:0]  resp;
      int          err_before;
      void'($urandom(74137));
      axil_req <= '0;
      arst_n   <= 1'b0;
      load_tests();
      repeat (4) @(posedge vga_clk);
      @(negedge vga_clk);
      // outputs while reset is held
      check_value("pixel_de", 0, {31'd0, pixel_de});
      check_value("pixel_data", 0, {31'd0, pixel_data});
      check_value("h_sync", 0, {31'd0, h_sync});
      check_value("v_sync", 0, {31'd0, v_sync});
      check_value("is_80col", 0, {31'd0, is_80col});
      check_value("b_valid", 0, {31'd0, axil_rsp.b_valid});
      check_value("r_valid", 0, {31'd0, axil_rsp.r_valid});
      $display("test 0 reset state: %s", (errors == 0) ? "ok" : "failed");
      if (errors != 0)
         tests_failed++;
      @(posedge vga_clk);
      arst_n <= 1'b1;
      repeat (3) @(posedge vga_clk);
      foreach (ops[i])
      begin
         err_before = errors;
         case (ops[i].kind)
            "W":
            begin
               axil_write(ops[i].a[15:0], ops[i].b, resp);
               check_value("b_resp", ops[i].c, {30'd0, resp});
            end
            "R":
            begin
               axil_read(ops[i].a[15:0], rdata, resp);
               check_value("r_data", ops[i].b, rdata);
               check_value("r_resp", ops[i].c, {30'd0, resp});
            end
            "F": capture_frame(ops[i].a[0]);
            "S": check_sync(ops[i]);
            default:
               check_value($sformatf("pixel_data line %0d x %0d", ops[i].a, ops[i].b),
                           ops[i].c, {31'd0, frame_lines[ops[i].a][ops[i].b]});
         endcase
         if (errors != err_before)
            tests_failed++;
         $display("test %0d %c %0h %0h %0h: %s", i + 1, ops[i].kind, ops[i].a, ops[i].b,
                  ops[i].c, (errors == err_before) ? "ok" : "failed");
      end
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               ops.size() + 1, tests_failed, checks, errors);
      if (errors == 0 && tests_failed == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

//--- sim.f
+incdir+.
trs_video_pkg.sv
video_ram.sv
host_bus_port.sv
raster_timing.sv
glyph_shifter.sv
trs_video_top.sv
tb_trs_video.sv

//--- Makefile
TOP = tb_trs_video

all: run

obj_dir/V$(TOP): sim.f *.sv *.svh
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@! grep -q "SOME TESTS FAILED" sim.log
	@grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

//--- tb_testdata.txt
# W addr data resp | R addr data resp   (hex, resp 0 OKAY, 2 SLVERR)
# F is_80col | P line x bit | S h_period h_width v_width v_period   (decimal, clocks)
R 8000 0 0
W 0154 41 0
W 5040 a5 0
W 5044 3c 0
W 0000 42 0
W 5080 c3 0
W 0004 81 0
W 0008 c1 0
W 6040 18 0
R 0154 41 0
R 5044 3c 0
R 0004 81 0
R 6040 18 0
W 2000 77 2
R 2000 0 2
R 8004 0 2
S 800 96 1600 420000
# 80x24, code 41 at row 1 col 5, code 42 at row 0 col 0, block 81 at col 1
W 8000 4 0
R 8000 4 0
F 1
P 20 40 1
P 20 41 0
P 20 47 1
P 21 45 1
P 22 40 0
P 22 42 1
P 0 0 1
P 0 2 0
P 0 8 1
P 0 12 0
# 64x16, text window starts at cell 8 line 48
W 8000 0 0
F 0
P 48 64 1
P 48 66 0
P 48 70 1
P 48 63 0
P 47 64 0
P 48 576 0
P 432 64 0
P 48 72 1
P 48 76 0
P 55 72 1
P 56 72 0
# inverse video, then alternate set
W 8000 2 0
F 0
P 48 80 0
P 48 81 1
P 48 84 1
P 48 64 1
W 8000 1 0
F 0
P 48 80 0
P 48 83 1
P 48 87 0
P 48 72 1
